// File: Bender.yml
package:
  name: rv32i_ooo_core

sources:
  - files:
      - design/rv_pkg.sv
      - design/inst_fetch.sv
      - design/issue_unit.sv
      - design/reg_file.sv
      - design/reorder_buf.sv
      - design/res_station.sv
      - design/cpu.sv
  - target: simulation
    files:
      - bench/cpu_assert.sv
      - bench/cpu_tb.sv

// File: bench/cpu_assert.sv
// bus, freeze and reset rules of the core, bound into cpu
// assumes sequential fetch with no branches; fail_count counts failed checks
`timescale 1ns/1ns
`default_nettype none

module cpu_assert (
    input logic            clk_in,
    input logic            rst_in,
    input logic            rdy_in,
    input rv_pkg::xlen_t   mem_a,
    input rv_pkg::commit_t commit,
    input logic            issue_take
);
    int fail_count = 0;

    after_reset: assert property (@(posedge clk_in) rst_in |=> !commit.valid && mem_a == '0)
        else begin fail_count++; $error("commit or mem_a not cleared by reset"); end

    frozen_commit: assert property (@(posedge clk_in) disable iff (rst_in)
        !rdy_in |-> !commit.valid)
        else begin fail_count++; $error("commit while rdy_in low"); end

    frozen_bus: assert property (@(posedge clk_in) disable iff (rst_in)
        !rdy_in |=> mem_a == $past(mem_a))
        else begin fail_count++; $error("mem_a moved while rdy_in low"); end

    // byte reads walk up one address at a time, or hold
    bus_step: assert property (@(posedge clk_in) disable iff (rst_in)
        rdy_in |=> (mem_a == $past(mem_a) || mem_a == $past(mem_a) + 32'd1))
        else begin fail_count++; $error("mem_a jumped"); end

    fetch_align: assert property (@(posedge clk_in) disable iff (rst_in)
        issue_take |=> mem_a[1:0] == 2'b00)
        else begin fail_count++; $error("fetch group not word aligned"); end

    x0_zero: assert property (@(posedge clk_in) disable iff (rst_in)
        commit.valid && commit.rd == '0 |-> commit.value == '0)
        else begin fail_count++; $error("commit to x0 with nonzero value"); end

endmodule

bind cpu cpu_assert cpu_assert_i (.*);

`default_nettype wire

// File: bench/cpu_tb.sv
// random 40-instruction OP, OP-IMM and LUI program checked against an in-order model
// register fields limited to x0..x7, rdy_in dropped for short random spans
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;
    import rv_pkg::*;

    localparam int N_INST       = 40;
    localparam int PROG_BYTES   = N_INST * INST_BYTES;
    localparam int RST_CYCLES   = 5;
    localparam int CYC_PER_INST = 16;       // fetch alone takes 5

    logic       clk_in;
    logic       rst_in;
    logic       rdy_in;
    logic [7:0] mem_din;
    xlen_t      mem_a;
    commit_t    commit;

    logic [7:0] mem      [PROG_BYTES];      // program bytes, zero beyond
    xlen_t      ref_regs [32];              // in-order model state
    reg_id_t    exp_rd   [N_INST];
    xlen_t      exp_val  [N_INST];
    xlen_t      bus_addr;                   // address taken at the last active edge
    int         pause_left;
    int         pause_total;
    int         cycles;
    int         n_done;

    cpu #(.ROB_BIT(3), .RS_SIZE(4)) cpu_i (.*);

    initial
    begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic logic [7:0] read_byte(xlen_t a);
        if (a < PROG_BYTES)
            return mem[a];
        else
            return 8'h00;                   // opcode 0, retires as a nop
    endfunction

    // one random kept instruction
    function automatic xlen_t gen_inst();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        r   = $urandom();
        rd  = {2'b00, r[2:0]};
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        f3  = r[11:9];
        f7  = (r[12] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
        if (f3 == 3'b001)
            imm = {7'b0000000, r[17:13]};   // slli
        else if (f3 == 3'b101)
            imm = {f7, r[17:13]};           // srli or srai
        else
            imm = r[23:12];
        case ($urandom_range(4))
            0:       return {r[31:12], rd, OPC_LUI};
            1, 2:    return {f7, rs2, rs1, f3, rd, OPC_OP};
            default: return {imm, rs1, f3, rd, OPC_OP_IMM};
        endcase
    endfunction

    // result of one instruction under the rv32i rules, from ref_regs
    function automatic xlen_t exec_ref(xlen_t ins);
        xlen_t              a;
        xlen_t              b;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [4:0]         sh;
        logic               alt;
        if (ins[6:0] == OPC_LUI)
            return {ins[31:12], 12'h000};
        a = ref_regs[ins[19:15]];
        if (ins[6:0] == OPC_OP)
            b = ref_regs[ins[24:20]];
        else
            b = {{20{ins[31]}}, ins[31:20]};
        sa  = a;
        sb  = b;
        sh  = b[4:0];                       // low 5 bits only
        alt = ins[30];
        case (ins[14:12])
            3'b000:  return (ins[6:0] == OPC_OP && alt) ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return {31'b0, sa < sb};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:
            begin
                if (alt)
                    return sa >>> sh;       // sign fills from the top
                else
                    return a >> sh;
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_program();
        xlen_t ins;
        xlen_t val;
        for (int r = 0; r < 32; r++)
            ref_regs[r] = '0;
        for (int i = 0; i < N_INST; i++)
        begin
            ins = gen_inst();
            val = exec_ref(ins);
            for (int k = 0; k < INST_BYTES; k++)
                mem[i * INST_BYTES + k] = ins[k * BYTE_W +: BYTE_W];   // little-endian
            exp_rd[i]  = ins[11:7];
            exp_val[i] = (ins[11:7] == '0) ? '0 : val;
            if (ins[11:7] != '0)
                ref_regs[ins[11:7]] = val;
        end
    endtask

    // called on each falling edge once reset is released
    task automatic drive_bus();
        mem_din <= read_byte(bus_addr);
        if (pause_left == 0 && $urandom_range(15) == 0)
        begin
            pause_left  = $urandom_range(4, 1);
            pause_total = pause_total + pause_left;
        end
        rdy_in <= (pause_left == 0);
        if (pause_left == 0)
            bus_addr = mem_a;               // consumed by the coming edge
        else
            pause_left = pause_left - 1;
    endtask

    always @(posedge clk_in)
    begin
        if (!rst_in)
        begin
            cycles = cycles + 1;
            if (cpu_i.cpu_assert_i.fail_count != 0)
                abort_run("a bound assertion on the bus, freeze or reset rules failed");
            else if (cycles > N_INST * CYC_PER_INST + pause_total)
                abort_run($sformatf("timeout with %0d of %0d instructions committed",
                                    n_done, N_INST));
            else if (commit.valid && n_done < N_INST)
            begin
                assert (commit.rd == exp_rd[n_done] && commit.value == exp_val[n_done])
                else abort_run($sformatf(
                    "FAILED commit %0d: expected rd x%0d value %h, actual rd x%0d value %h",
                    n_done, exp_rd[n_done], exp_val[n_done], commit.rd, commit.value));
                n_done = n_done + 1;
            end
        end
    end

    initial
    begin
        void'($urandom(45649));
        rst_in      = 1'b1;
        rdy_in      = 1'b1;
        mem_din     = 8'h00;
        bus_addr    = '0;
        pause_left  = 0;
        pause_total = 0;
        cycles      = 0;
        n_done      = 0;
        build_program();
        repeat (RST_CYCLES) @(posedge clk_in);
        @(negedge clk_in);
        rst_in <= 1'b0;
        while (n_done < N_INST)
        begin
            drive_bus();
            @(negedge clk_in);
        end
        if (cpu_i.cpu_assert_i.fail_count == 0)
        begin
            $display("all tests passed");
            $finish;
        end
        else
            abort_run("a bound assertion failed near the last commit");
    end

endmodule

`default_nettype wire

// File: design/cpu.sv
// out-of-order rv32i core, integer ALU ops and LUI only, no loads or stores
// rdy_in low freezes all state; mem_a reads return on mem_din a cycle later
`timescale 1ns/1ns
`default_nettype none

module cpu #(
    parameter int ROB_BIT = 3,      // rob depth is 2**ROB_BIT, at most 8
    parameter int RS_SIZE = 4
) (
    input  logic            clk_in,
    input  logic            rst_in,
    input  logic            rdy_in,
    input  logic [7:0]      mem_din,
    output rv_pkg::xlen_t   mem_a,
    output rv_pkg::commit_t commit      // one retired instruction per cycle
);
    import rv_pkg::*;

    logic               inst_valid;
    xlen_t              inst;
    logic               issue_take;
    logic               rob_full;
    logic [ROB_BIT-1:0] rob_tail;
    logic               rs_full;
    reg_id_t            rs1;
    reg_id_t            rs2;
    xlen_t              src1_value;
    logic               src1_dep;
    tag_t               src1_tag;
    xlen_t              src2_value;
    logic               src2_dep;
    tag_t               src2_tag;
    logic               issue_rob;
    logic               rename;
    reg_id_t            rd;
    logic               issue_rs;
    issue_t             issue;
    result_t            result;         // alu broadcast
    tag_t               fwd_tag1;
    tag_t               fwd_tag2;
    logic               fwd_ready1;
    xlen_t              fwd_value1;
    logic               fwd_ready2;
    xlen_t              fwd_value2;
    tag_t               commit_tag;

    inst_fetch inst_fetch_i (
        .inst_addr(),                   // pc of held inst, no branches to use it
        .*
    );

    issue_unit #(.ROB_BIT(ROB_BIT)) issue_unit_i (.*);

    reg_file #(.ROB_BIT(ROB_BIT)) reg_file_i (
        .dest_tag(issue.dest_tag),      // rename goes with the rob slot
        .*
    );

    reorder_buf #(.ROB_BIT(ROB_BIT)) reorder_buf_i (.*);

    res_station #(.ROB_BIT(ROB_BIT), .RS_SIZE(RS_SIZE)) res_station_i (.*);

endmodule

`default_nettype wire

// File: design/inst_fetch.sv
// sequential fetch, one instruction as four byte reads, little-endian
// the byte for mem_a returns one cycle later; no branches, so pc only steps by 4
`timescale 1ns/1ns
`default_nettype none

module inst_fetch (
    input  logic          clk_in,
    input  logic          rst_in,
    input  logic          rdy_in,       // low freezes pc and counter
    input  logic [7:0]    mem_din,
    output rv_pkg::xlen_t mem_a,
    input  logic          issue_take,   // issue consumed inst this cycle
    output logic          inst_valid,
    output rv_pkg::xlen_t inst,
    output rv_pkg::xlen_t inst_addr
);
    import rv_pkg::*;

    localparam int CNT_W = $clog2(INST_BYTES) + 1;

    xlen_t            pc;
    logic [CNT_W-1:0] byte_cnt;     // byte reads sent for current word

    assign mem_a     = pc + xlen_t'(byte_cnt);  // sits at pc+4 while inst waits
    assign inst_addr = pc;

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            pc         <= '0;
            byte_cnt   <= '0;
            inst_valid <= 1'b0;
        end
        else if (rdy_in)
        begin
            if (inst_valid)
            begin
                if (issue_take)                 // start next word
                begin
                    pc         <= pc + xlen_t'(INST_BYTES);
                    byte_cnt   <= '0;
                    inst_valid <= 1'b0;
                end
            end
            else if (byte_cnt == CNT_W'(INST_BYTES))
            begin
                inst_valid <= 1'b1;             // last byte captured this edge
            end
            else
            begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // byte k-1 is on mem_din while byte_cnt == k
    always_ff @(posedge clk_in)
    begin
        if (rdy_in && !inst_valid && byte_cnt != '0)
            inst <= {mem_din, inst[XLEN-1:BYTE_W]};  // shift in from the top
    end

endmodule

`default_nettype wire

// File: design/issue_unit.sv
// decodes OP, OP-IMM and LUI; other opcodes retire as an add to x0
// decode is registered, so issue comes at least one cycle after inst_valid
`timescale 1ns/1ns
`default_nettype none

module issue_unit #(
    parameter int ROB_BIT = 3
) (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               rdy_in,
    input  logic               inst_valid,
    input  rv_pkg::xlen_t      inst,
    output logic               issue_take,
    input  logic               rob_full,
    input  logic [ROB_BIT-1:0] rob_tail,
    input  logic               rs_full,
    output rv_pkg::reg_id_t    rs1,
    output rv_pkg::reg_id_t    rs2,
    input  rv_pkg::xlen_t      src1_value,
    input  logic               src1_dep,
    input  rv_pkg::tag_t       src1_tag,
    input  rv_pkg::xlen_t      src2_value,
    input  logic               src2_dep,
    input  rv_pkg::tag_t       src2_tag,
    output logic               issue_rob,
    output logic               rename,
    output rv_pkg::reg_id_t    rd,
    output logic               issue_rs,
    output rv_pkg::issue_t     issue
);
    import rv_pkg::*;

    alu_op_t op_c;
    reg_id_t rd_c;
    reg_id_t rs1_c;
    logic    use_imm_c;
    xlen_t   imm_c;

    logic    dec_valid;     // decode regs hold the waiting inst
    alu_op_t dec_op;
    reg_id_t dec_rd;
    reg_id_t dec_rs1;
    reg_id_t dec_rs2;
    logic    dec_use_imm;
    xlen_t   dec_imm;
    logic    go;

    always_comb
    begin
        op_c      = ALU_ADD;
        rd_c      = inst[11:7];
        rs1_c     = inst[19:15];
        use_imm_c = 1'b1;
        imm_c     = {{20{inst[31]}}, inst[31:20]};      // I-type, shamt in low 5 bits
        case (inst[6:0])
            OPC_OP, OPC_OP_IMM:
            begin
                use_imm_c = (inst[6:0] == OPC_OP_IMM);
                case (inst[14:12])
                    3'b000:  op_c = (inst[6:0] == OPC_OP && inst[30]) ? ALU_SUB : ALU_ADD;
                    3'b001:  op_c = ALU_SLL;
                    3'b010:  op_c = ALU_SLT;
                    3'b011:  op_c = ALU_SLTU;
                    3'b100:  op_c = ALU_XOR;
                    3'b101:  op_c = inst[30] ? ALU_SRA : ALU_SRL;
                    3'b110:  op_c = ALU_OR;
                    default: op_c = ALU_AND;
                endcase
            end
            OPC_LUI:
            begin
                op_c  = ALU_LUI;
                rs1_c = '0;                             // no false dependency
                imm_c = {inst[31:12], 12'b0};
            end
            default:
            begin
                rd_c  = '0;                             // writes nothing, still commits
                rs1_c = '0;
                imm_c = '0;
            end
        endcase
    end

    assign go = rdy_in && inst_valid && dec_valid && !rob_full && !rs_full;

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
            dec_valid <= 1'b0;
        else if (rdy_in)
        begin
            if (go)
                dec_valid <= 1'b0;
            else if (inst_valid)
                dec_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (rdy_in && inst_valid && !dec_valid)
        begin
            dec_op      <= op_c;
            dec_rd      <= rd_c;
            dec_rs1     <= rs1_c;
            dec_rs2     <= inst[24:20];             // ignored when imm used
            dec_use_imm <= use_imm_c;
            dec_imm     <= imm_c;
        end
    end

    assign issue_take = go;
    assign issue_rob  = go;
    assign issue_rs   = go;
    assign rename     = go && (dec_rd != '0);
    assign rd         = dec_rd;
    assign rs1        = dec_rs1;
    assign rs2        = dec_rs2;

    always_comb
    begin
        issue.alu_op   = dec_op;
        issue.val1     = src1_value;
        issue.dep1     = src1_dep;
        issue.tag1     = src1_tag;
        issue.val2     = dec_use_imm ? dec_imm : src2_value;
        issue.dep2     = !dec_use_imm && src2_dep;     // immediate never waits
        issue.tag2     = src2_tag;
        issue.dest_tag = tag_t'(rob_tail);             // next free rob slot
    end

endmodule

`default_nettype wire

// File: design/reg_file.sv
// 32 architectural registers with a rename tag and busy flag each
// reads are combinational and see a same-cycle commit and ready rob entries
`timescale 1ns/1ns
`default_nettype none

module reg_file #(
    parameter int ROB_BIT = 3
) (
    input  logic            clk_in,
    input  logic            rst_in,
    input  logic            rdy_in,
    input  rv_pkg::reg_id_t rs1,
    input  rv_pkg::reg_id_t rs2,
    output rv_pkg::xlen_t   src1_value,
    output logic            src1_dep,
    output rv_pkg::tag_t    src1_tag,
    output rv_pkg::xlen_t   src2_value,
    output logic            src2_dep,
    output rv_pkg::tag_t    src2_tag,
    input  logic            rename,
    input  rv_pkg::reg_id_t rd,
    input  rv_pkg::tag_t    dest_tag,
    input  rv_pkg::commit_t commit,
    input  rv_pkg::tag_t    commit_tag,
    output rv_pkg::tag_t    fwd_tag1,
    output rv_pkg::tag_t    fwd_tag2,
    input  logic            fwd_ready1,
    input  rv_pkg::xlen_t   fwd_value1,
    input  logic            fwd_ready2,
    input  rv_pkg::xlen_t   fwd_value2
);
    import rv_pkg::*;

    xlen_t              regs [32];
    logic [ROB_BIT-1:0] tags [32];  // youngest in-flight writer
    logic [31:0]        busy;       // dep flag per register

    // {dep, value} for one source register
    function automatic logic [XLEN:0] read_src(reg_id_t rs, logic fwd_ready, xlen_t fwd_value);
        logic [XLEN:0] res;
        res = {1'b0, regs[rs]};
        if (rs == '0)
            res = '0;                                   // x0 hardwired
        else if (busy[rs])
        begin
            if (commit.valid && commit.rd == rs && commit_tag[ROB_BIT-1:0] == tags[rs])
                res = {1'b0, commit.value};             // retiring this cycle
            else if (fwd_ready)
                res = {1'b0, fwd_value};                // done, not yet retired
            else
                res = {1'b1, regs[rs]};
        end
        return res;
    endfunction

    always_comb
    begin
        {src1_dep, src1_value} = read_src(rs1, fwd_ready1, fwd_value1);
        {src2_dep, src2_value} = read_src(rs2, fwd_ready2, fwd_value2);
    end

    assign src1_tag = tag_t'(tags[rs1]);
    assign src2_tag = tag_t'(tags[rs2]);
    assign fwd_tag1 = tag_t'(tags[rs1]);    // rob lookup of the pending writer
    assign fwd_tag2 = tag_t'(tags[rs2]);

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            busy <= '0;
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end
        else if (rdy_in)
        begin
            if (commit.valid && commit.rd != '0)
            begin
                regs[commit.rd] <= commit.value;
                if (tags[commit.rd] == commit_tag[ROB_BIT-1:0])
                    busy[commit.rd] <= 1'b0;    // last writer retired
            end
            if (rename && rd != '0)
            begin
                busy[rd] <= 1'b1;               // beats a same-cycle clear
                tags[rd] <= dest_tag[ROB_BIT-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/reorder_buf.sv
// circular reorder buffer of 2**ROB_BIT entries, one commit per cycle
// an entry is filled by the alu broadcast and retires from the head when ready
`timescale 1ns/1ns
`default_nettype none

module reorder_buf #(
    parameter int ROB_BIT = 3
) (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               rdy_in,
    input  logic               issue_rob,
    input  rv_pkg::reg_id_t    rd,
    output logic               rob_full,
    output logic [ROB_BIT-1:0] rob_tail,
    input  rv_pkg::result_t    result,
    input  rv_pkg::tag_t       fwd_tag1,
    input  rv_pkg::tag_t       fwd_tag2,
    output logic               fwd_ready1,
    output rv_pkg::xlen_t      fwd_value1,
    output logic               fwd_ready2,
    output rv_pkg::xlen_t      fwd_value2,
    output rv_pkg::commit_t    commit,
    output rv_pkg::tag_t       commit_tag
);
    import rv_pkg::*;

    localparam int DEPTH = 1 << ROB_BIT;

    reg_id_t            ent_rd    [DEPTH];
    xlen_t              ent_value [DEPTH];
    logic [DEPTH-1:0]   ent_ready;
    logic [ROB_BIT-1:0] head;
    logic [ROB_BIT-1:0] tail;
    logic [ROB_BIT:0]   count;
    logic               retire;

    assign rob_full = count[ROB_BIT];       // count reached DEPTH
    assign rob_tail = tail;
    assign retire   = rdy_in && count != '0 && ent_ready[head];

    always_comb
    begin
        commit.valid = retire;
        commit.rd    = ent_rd[head];
        commit.value = (ent_rd[head] == '0) ? '0 : ent_value[head];  // x0 reports zero
    end

    assign commit_tag = tag_t'(head);

    // lookups from reg_file for pending source registers
    assign fwd_ready1 = ent_ready[fwd_tag1[ROB_BIT-1:0]];
    assign fwd_value1 = ent_value[fwd_tag1[ROB_BIT-1:0]];
    assign fwd_ready2 = ent_ready[fwd_tag2[ROB_BIT-1:0]];
    assign fwd_value2 = ent_value[fwd_tag2[ROB_BIT-1:0]];

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_ready <= '0;
        end
        else if (rdy_in)
        begin
            if (result.valid)
                ent_ready[result.tag[ROB_BIT-1:0]] <= 1'b1;
            if (issue_rob)
            begin
                ent_ready[tail] <= 1'b0;        // tail slot is never the result slot
                tail            <= tail + 1'b1;
            end
            if (retire)
                head <= head + 1'b1;
            count <= count + {{ROB_BIT{1'b0}}, issue_rob} - {{ROB_BIT{1'b0}}, retire};
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (rdy_in)
        begin
            if (issue_rob)
                ent_rd[tail] <= rd;
            if (result.valid)
                ent_value[result.tag[ROB_BIT-1:0]] <= result.value;
        end
    end

endmodule

`default_nettype wire

// File: design/res_station.sv
// RS_SIZE-entry reservation station feeding the single ALU
// lowest-index ready entry fires, result is registered and broadcast next cycle
`timescale 1ns/1ns
`default_nettype none

module res_station #(
    parameter int ROB_BIT = 3,
    parameter int RS_SIZE = 4
) (
    input  logic            clk_in,
    input  logic            rst_in,
    input  logic            rdy_in,
    input  logic            issue_rs,
    input  rv_pkg::issue_t  issue,
    output logic            rs_full,
    output rv_pkg::result_t result
);
    import rv_pkg::*;

    localparam int IDX_W = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;

    issue_t             ent [RS_SIZE];
    logic [RS_SIZE-1:0] busy;
    logic [IDX_W-1:0]   free_idx;
    logic [IDX_W-1:0]   fire_idx;
    logic               fire;
    xlen_t              alu_out;
    logic               res_valid;
    tag_t               res_tag;
    xlen_t              res_value;

    // take the broadcast value for any operand still waiting on its tag
    function automatic issue_t capture(issue_t e, result_t r);
        issue_t c;
        c = e;
        if (r.valid && e.dep1 && e.tag1[ROB_BIT-1:0] == r.tag[ROB_BIT-1:0])
        begin
            c.val1 = r.value;
            c.dep1 = 1'b0;
        end
        if (r.valid && e.dep2 && e.tag2[ROB_BIT-1:0] == r.tag[ROB_BIT-1:0])
        begin
            c.val2 = r.value;
            c.dep2 = 1'b0;
        end
        return c;
    endfunction

    function automatic xlen_t alu(alu_op_t op, xlen_t a, xlen_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << b[4:0];
            ALU_SLT:  return xlen_t'($signed(a) < $signed(b));
            ALU_SLTU: return xlen_t'(a < b);
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return xlen_t'($signed(a) >>> b[4:0]);
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return b;     // lui
        endcase
    endfunction

    always_comb
    begin
        free_idx = '0;
        fire_idx = '0;
        fire     = 1'b0;
        for (int i = RS_SIZE - 1; i >= 0; i--)  // downward, lowest index wins
        begin
            if (!busy[i])
                free_idx = IDX_W'(i);
            if (busy[i] && !ent[i].dep1 && !ent[i].dep2)
            begin
                fire     = 1'b1;
                fire_idx = IDX_W'(i);
            end
        end
    end

    assign rs_full = &busy;
    assign alu_out = alu(ent[fire_idx].alu_op, ent[fire_idx].val1, ent[fire_idx].val2);
    assign result  = '{valid: res_valid, tag: res_tag, value: res_value};

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            busy      <= '0;
            res_valid <= 1'b0;
        end
        else if (rdy_in)
        begin
            if (fire)
                busy[fire_idx] <= 1'b0;
            if (issue_rs)
                busy[free_idx] <= 1'b1;     // never the firing slot, that one is busy
            res_valid <= fire;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (rdy_in)
        begin
            for (int i = 0; i < RS_SIZE; i++)
                ent[i] <= capture(ent[i], result);
            if (issue_rs)
                ent[free_idx] <= capture(issue, result);   // same-cycle broadcast too
            res_tag   <= ent[fire_idx].dest_tag;
            res_value <= alu_out;
        end
    end

endmodule

`default_nettype wire

// File: design/rv_pkg.sv
// shared types for the rv32i core, covering OP, OP-IMM and LUI only
// tag fields are fixed at 8 bits, so ROB_BIT may not exceed 8
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int BYTE_W     = 8;    // memory bus width
    localparam int INST_BYTES = 4;    // bytes per instruction
    localparam int TAG_W      = 8;    // max rob tag width, low ROB_BIT bits used

    typedef logic [XLEN-1:0]  xlen_t;
    typedef logic [4:0]       reg_id_t;
    typedef logic [TAG_W-1:0] tag_t;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_LUI     // operand 2 passes through
    } alu_op_t;

    // one instruction as handed to the reservation station
    typedef struct packed {
        alu_op_t alu_op;
        xlen_t   val1;
        xlen_t   val2;      // holds the immediate when one is used
        logic    dep1;      // val1 still waits on tag1
        logic    dep2;
        tag_t    tag1;
        tag_t    tag2;
        tag_t    dest_tag;  // rob slot of this instruction
    } issue_t;

    // alu broadcast, at most one per cycle
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        xlen_t value;
    } result_t;

    // in-order retirement, also the register file write
    typedef struct packed {
        logic    valid;
        reg_id_t rd;
        xlen_t   value;
    } commit_t;

endpackage

`default_nettype wire

// File: sim.f
design/rv_pkg.sv
design/inst_fetch.sv
design/issue_unit.sv
design/reg_file.sv
design/reorder_buf.sv
design/res_station.sv
design/cpu.sv
bench/cpu_assert.sv
bench/cpu_tb.sv
